// ==== all.f ====
+incdir+hdl
hdl/riscvPkg.sv
hdl/fetchStage.sv
hdl/decodeControl.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/executeStage.sv
hdl/writebackStage.sv
hdl/riscvCore.sv
tests/riscvCore_assert.sv
tests/riscvCoreTb.sv

// ==== Makefile ====
# Verilator flow for the RV32I core testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f all.f --top-module riscvCoreTb

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module riscvCoreTb \
		-Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/riscvCoreTb.sv ====
// RV32I core testbench
`timescale 1ns/100ps
`include "riscv_defs.svh"

module riscvCoreTb;

   // Each test needs about five cycles per program word, summed over six tests
   localparam int MaxCycles = 2000;

   logic             clk;
   logic             rst;
   logic             stall;
   logic             loadEn;
   logic [7:0]       loadAddr;
   logic [`XLEN-1:0] loadData;
   logic             ioValid;
   logic [`XLEN-1:0] ioData;

   logic [31:0] prog[$];
   logic [31:0] expq[$];
   logic [31:0] gotq[$];
   logic [31:0] savedProg[$];
   logic [31:0] savedExp[$];
   logic [31:0] chainOut[$];
   bit          padMode;
   integer      seed;
   int          errors = 0;
   int          testsRun = 0;
   int          cycleCount = 0;

   riscvCore u_riscvCore (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .ioValid  (ioValid),
      .ioData   (ioData)
   );

   bind riscvCore riscvCore_assert u_assert (
      .clk     (clk),
      .rst     (rst),
      .stall   (stall),
      .ioValid (ioValid),
      .memWe   (memWe),
      .memAddr (memAddr),
      .pc      (pc)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= MaxCycles)
      begin
         $display("Timeout: run exceeded %0d cycles", MaxCycles);
         $display("Checks failed");
         $finish;
      end
   end

   // Reference semantics of the RV32I integer operations
   function automatic logic [31:0] rvCalc(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      logic signed [31:0] sa;
      sa = a;
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5:
         begin
            if (alt)
               return sa >>> b[4:0];
            return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] pcNow();
      return 32'(prog.size() * 4);
   endfunction

   // Instruction emitters
   task automatic emit(input logic [31:0] word);
      prog.push_back(word);
      if (padMode)
         prog.push_back(`NOP_INSTR);
   endtask

   task automatic emitR(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
      emit({f7, rs2, rs1, f3, rd, 7'b0110011});
   endtask

   task automatic emitI(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
      emit({imm, rs1, f3, rd, opc});
   endtask

   task automatic emitU(input logic [6:0] opc, input logic [4:0] rd, input logic [19:0] imm);
      emit({imm, rd, opc});
   endtask

   task automatic emitSw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
      emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
   endtask

   task automatic emitBranch(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [12:0] off);
      emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011});
   endtask

   task automatic emitJal(input logic [4:0] rd, input logic [20:0] off);
      emit({off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111});
   endtask

   task automatic emitIo(input logic [4:0] rs);
      emitSw(rs, 5'd10, 12'd0);
   endtask

   task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = (v + 32'h800) >> 12;
      emitU(7'b0110111, rd, hi[19:0]);
      emitI(7'b0010011, 3'd0, rd, rd, v[11:0]);
   endtask

   // x10 holds the output address in every program
   task automatic startProgram();
      prog.delete();
      expq.delete();
      emitU(7'b0110111, 5'd10, 20'(`IO_ADDR >> 12));
   endtask

   // Park the core on a self loop
   task automatic finishProgram();
      emitJal(5'd0, 21'd0);
   endtask

   task automatic checkValue(input string sig, input logic [31:0] expVal,
                             input logic [31:0] gotVal);
      assert (gotVal === expVal)
      else
      begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, sig, expVal, gotVal);
         errors++;
      end
   endtask

   // Load under reset, release, and collect the output stores
   task automatic runProgram(input string name, input bit useStall, input int firstCycle);
      int errBefore;
      int cycles;
      int limit;
      int stallLeft;
      errBefore = errors + u_riscvCore.u_assert.failCount;
      cycles = 0;
      stallLeft = 0;
      limit = 4 * prog.size() + 40;
      gotq.delete();
      @(negedge clk);
      rst = 1'b1;
      stall = 1'b0;
      foreach (prog[i])
      begin
         loadEn = 1'b1;
         loadAddr = 8'(i);
         loadData = prog[i];
         @(negedge clk);
      end
      loadEn = 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         assert (!ioValid)
         else
         begin
            $display("%s: ioValid went high during reset", name);
            errors++;
         end
      end
      rst = 1'b0;
      while (gotq.size() < expq.size() && cycles < limit)
      begin
         @(negedge clk);
         cycles++;
         if (firstCycle > 0 && gotq.size() == 0)
         begin
            assert (ioValid == (cycles == firstCycle))
            else
            begin
               $display("%s: ioValid was %b on cycle %0d after reset, first output due on %0d",
                        name, ioValid, cycles, firstCycle);
               errors++;
            end
         end
         assert (!(stall && ioValid))
         else
         begin
            $display("%s: ioValid high while stall is high", name);
            errors++;
         end
         if (ioValid)
         begin
            checkValue("ioData", expq[gotq.size()], ioData);
            gotq.push_back(ioData);
         end
         if (!useStall)
            stall = 1'b0;
         else if (stallLeft > 0)
         begin
            stall = 1'b1;
            stallLeft--;
         end
         else if (($random(seed) & 3) == 0)
         begin
            stall = 1'b1;
            stallLeft = $random(seed) & 3;
         end
         else
            stall = 1'b0;
      end
      stall = 1'b0;
      assert (gotq.size() == expq.size())
      else
      begin
         $display("%s: only %0d of %0d outputs appeared", name, gotq.size(), expq.size());
         errors++;
      end
      // Nothing more may leave the parked core
      repeat (6)
      begin
         @(negedge clk);
         assert (!ioValid)
         else
         begin
            $display("%s: an output appeared after the last expected one", name);
            errors++;
         end
      end
      testsRun++;
      $display("%s: %s", name,
               (errors + u_riscvCore.u_assert.failCount == errBefore) ? "passed" : "failed");
   endtask

   task automatic arithTest();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] here;
      logic [11:0] immField;
      a = $random(seed);
      b = $random(seed);
      startProgram();
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      emitU(7'b0110111, 5'd3, a[31:12]);
      emitIo(5'd3);
      expq.push_back({a[31:12], 12'b0});
      here = pcNow();
      emitU(7'b0010111, 5'd4, b[19:0]);
      emitIo(5'd4);
      expq.push_back(here + {b[19:0], 12'b0});
      for (int f3 = 0; f3 < 8; f3++)
      begin
         emitR(7'h00, 3'(f3), 5'd3, 5'd1, 5'd2);
         emitIo(5'd3);
         expq.push_back(rvCalc(3'(f3), 1'b0, a, b));
         if (f3 == 0 || f3 == 5)
         begin
            emitR(7'h20, 3'(f3), 5'd3, 5'd1, 5'd2);
            emitIo(5'd3);
            expq.push_back(rvCalc(3'(f3), 1'b1, a, b));
         end
      end
      for (int f3 = 0; f3 < 8; f3++)
      begin
         immField = 12'($random(seed));
         if (f3 == 1 || f3 == 5)
            immField = {7'b0, immField[4:0]};
         emitI(7'b0010011, 3'(f3), 5'd3, 5'd1, immField);
         emitIo(5'd3);
         expq.push_back(rvCalc(3'(f3), 1'b0, a, {{20{immField[11]}}, immField}));
         if (f3 == 5)
         begin
            emitI(7'b0010011, 3'd5, 5'd3, 5'd1, {7'b0100000, immField[4:0]});
            emitIo(5'd3);
            expq.push_back(rvCalc(3'd5, 1'b1, a, {27'b0, immField[4:0]}));
         end
      end
      finishProgram();
      savedProg = prog;
      savedExp = expq;
      runProgram("arithmetic", 1'b0, 0);
   endtask

   task automatic buildChain(input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r3, r4, r5, r6, r7, r8, r9, r11;
      startProgram();
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      r3 = a + b;
      r4 = r3 - a;
      r5 = r4 ^ r3;
      r6 = r5 << b[4:0];
      r7 = r6 | r4;
      r8 = r7 - 32'd5;
      r9 = (r8 < r7) ? 32'd1 : 32'd0;
      r11 = r9 & r8;
      emitR(7'h00, 3'd0, 5'd3, 5'd1, 5'd2);
      emitIo(5'd3);
      emitR(7'h20, 3'd0, 5'd4, 5'd3, 5'd1);
      emitR(7'h00, 3'd4, 5'd5, 5'd4, 5'd3);
      emitR(7'h00, 3'd1, 5'd6, 5'd5, 5'd2);
      emitR(7'h00, 3'd6, 5'd7, 5'd6, 5'd4);
      emitIo(5'd7);
      emitI(7'b0010011, 3'd0, 5'd8, 5'd7, 12'hFFB);
      emitR(7'h00, 3'd3, 5'd9, 5'd8, 5'd7);
      emitR(7'h00, 3'd7, 5'd11, 5'd9, 5'd8);
      emitIo(5'd11);
      finishProgram();
      expq.push_back(r3);
      expq.push_back(r7);
      expq.push_back(r11);
   endtask

   task automatic forwardTest();
      logic [31:0] a;
      logic [31:0] b;
      a = $random(seed);
      b = $random(seed);
      padMode = 1'b0;
      buildChain(a, b);
      runProgram("forwarding chained", 1'b0, 0);
      chainOut = gotq;
      padMode = 1'b1;
      buildChain(a, b);
      padMode = 1'b0;
      runProgram("forwarding padded", 1'b0, 0);
      foreach (chainOut[i])
      begin
         if (i < gotq.size())
            checkValue("ioData", gotq[i], chainOut[i]);
      end
   endtask

   task automatic memoryTest();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      startProgram();
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      loadConst(5'd3, c);
      emitSw(5'd1, 5'd0, 12'd0);
      emitSw(5'd2, 5'd0, 12'd8);
      emitSw(5'd3, 5'd0, 12'd1020);
      // Load used by the next instruction
      emitI(7'b0000011, 3'b010, 5'd4, 5'd0, 12'd8);
      emitR(7'h00, 3'd0, 5'd5, 5'd4, 5'd4);
      emitIo(5'd5);
      expq.push_back(b + b);
      emitI(7'b0000011, 3'b010, 5'd6, 5'd0, 12'd0);
      emitIo(5'd6);
      expq.push_back(a);
      emitI(7'b0000011, 3'b010, 5'd7, 5'd0, 12'd1020);
      emitIo(5'd7);
      expq.push_back(c);
      emitSw(5'd1, 5'd0, 12'd8);
      emitI(7'b0000011, 3'b010, 5'd8, 5'd0, 12'd8);
      emitIo(5'd8);
      expq.push_back(a);
      // Writes aimed at x0
      emitI(7'b0010011, 3'd0, 5'd0, 5'd1, 12'd0);
      emitIo(5'd0);
      expq.push_back(32'd0);
      emitR(7'h00, 3'd0, 5'd0, 5'd1, 5'd2);
      emitR(7'h00, 3'd0, 5'd12, 5'd0, 5'd0);
      emitIo(5'd12);
      expq.push_back(32'd0);
      emitI(7'b0000011, 3'b010, 5'd0, 5'd0, 12'd0);
      emitIo(5'd0);
      expq.push_back(32'd0);
      finishProgram();
      runProgram("memory", 1'b0, 0);
   endtask

   task automatic controlTest();
      logic [2:0]  brF3 [6];
      logic [4:0]  srcA [3];
      logic [4:0]  srcB [3];
      logic [31:0] regVal [1:4];
      logic [31:0] q;
      brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      srcA = '{5'd1, 5'd3, 5'd4};
      srcB = '{5'd2, 5'd4, 5'd3};
      regVal = '{32'd5, 32'd5, -32'sd3, 32'd7};
      startProgram();
      for (int r = 1; r <= 4; r++)
         emitI(7'b0010011, 3'd0, 5'(r), 5'd0, regVal[r][11:0]);
      loadConst(5'd22, 32'hBAD);
      loadConst(5'd23, 32'h600D);
      // Marker store sits in the slot a taken branch skips
      foreach (brF3[f])
      begin
         for (int p = 0; p < 3; p++)
         begin
            emitBranch(brF3[f], srcA[p], srcB[p], 13'd8);
            emitIo(5'd22);
            emitIo(5'd23);
            if (!branchTaken(brF3[f], regVal[srcA[p]], regVal[srcB[p]]))
               expq.push_back(32'hBAD);
            expq.push_back(32'h600D);
         end
      end
      q = pcNow();
      emitJal(5'd5, 21'd8);
      emitIo(5'd22);
      emitIo(5'd5);
      expq.push_back(q + 32'd4);
      // JALR target has bit 0 set before clearing
      q = pcNow() + 32'd4;
      emitI(7'b0010011, 3'd0, 5'd6, 5'd0, 12'(q + 32'd8));
      emitI(7'b1100111, 3'd0, 5'd7, 5'd6, 12'd1);
      emitIo(5'd22);
      emitIo(5'd7);
      expq.push_back(q + 32'd4);
      finishProgram();
      runProgram("control flow", 1'b0, 0);
   endtask

   task automatic stallTest();
      prog = savedProg;
      expq = savedExp;
      runProgram("stall", 1'b1, 0);
   endtask

   // Store at word 3 reaches W on the fifth cycle after reset
   task automatic resetTest();
      startProgram();
      emitI(7'b0010011, 3'd0, 5'd1, 5'd0, 12'h055);
      emitI(7'b0010011, 3'd0, 5'd2, 5'd1, 12'd1);
      emitIo(5'd2);
      expq.push_back(32'h56);
      finishProgram();
      runProgram("reset", 1'b0, 5);
   endtask

   initial
   begin
      seed = 24;
      rst = 1'b1;
      stall = 1'b0;
      loadEn = 1'b0;
      loadAddr = 8'd0;
      loadData = '0;
      padMode = 1'b0;
      repeat (3) @(negedge clk);
      arithTest();
      forwardTest();
      memoryTest();
      controlTest();
      stallTest();
      resetTest();
      // Failed bound assertions count as errors too
      errors += u_riscvCore.u_assert.failCount;
      $display("%0d tests run, %0d errors", testsRun, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== tests/riscvCore_assert.sv ====
// Core protocol assertions
`timescale 1ns/100ps

module riscvCore_assert (
   input logic        clk,
   input logic        rst,
   input logic        stall,
   input logic        ioValid,
   input logic        memWe,
   input logic [31:0] memAddr,
   input logic [31:0] pc
);

   // Failed assertions so far
   int failCount = 0;

   // No output pulse during reset or stall
   ioQuietInResetStall: assert property (@(posedge clk)
      (rst || stall) |-> (ioValid !== 1'b1))
      else
      begin
         $error("ioValid high while rst or stall is high");
         failCount++;
      end

   // A second pulse needs a second output store behind the first
   ioSinglePulse: assert property (@(posedge clk) disable iff (rst)
      ioValid |=> (!ioValid || $past(memWe && memAddr[31])))
      else
      begin
         $error("ioValid held for two cycles by one store");
         failCount++;
      end

   pcAligned: assert property (@(posedge clk) disable iff (rst)
      pc[1:0] == 2'b00)
      else
      begin
         $error("pc not word aligned");
         failCount++;
      end

endmodule

// ==== hdl/riscvCore.sv ====
// Three-stage RV32I core
`timescale 1ns/100ps
`include "riscv_defs.svh"

module riscvCore import riscvPkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall,
   input  logic               loadEn,
   input  logic [7:0]         loadAddr,
   input  logic [`XLEN-1:0]   loadData,
   output logic               ioValid,
   output logic [`XLEN-1:0]   ioData
);

   // Fetch to execute
   logic [`XLEN-1:0] instr, pc, target;
   logic             redirect;

   // Decode outputs
   logic [4:0]       rs1, rs2, rd;
   logic [`XLEN-1:0] imm;
   opcodeT           opcode;
   logic [2:0]       funct3;
   aluOpT            aluOp;
   logic             useImmB, useZeroA, usePcA, regWe;
   wbSelT            wbSel;
   logic             isBranch, isJal, isJalr, isLoad, isStore;

   // Register file and W stage
   logic [`XLEN-1:0] rd1, rd2, wbValue;
   logic             memWe, memRe;
   logic [`XLEN-1:0] memAddr, memWdata;
   logic [4:0]       wRd;
   logic             wRegWe;
   wbSelT            wWbSel;
   logic [`XLEN-1:0] wAluOut, wLink;

   fetchStage u_fetch (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .redirect (redirect),
      .target   (target),
      .instr    (instr),
      .pc       (pc)
   );

   decodeControl u_decode (
      .instr    (instr),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .imm      (imm),
      .opcode   (opcode),
      .funct3   (funct3),
      .aluOp    (aluOp),
      .useImmB  (useImmB),
      .useZeroA (useZeroA),
      .usePcA   (usePcA),
      .regWe    (regWe),
      .wbSel    (wbSel),
      .isBranch (isBranch),
      .isJal    (isJal),
      .isJalr   (isJalr),
      .isLoad   (isLoad),
      .isStore  (isStore)
   );

   // Written from W, read in X
   regFile u_regFile (
      .clk   (clk),
      .stall (stall),
      .we    (wRegWe),
      .ra1   (rs1),
      .ra2   (rs2),
      .wa    (wRd),
      .wd    (wbValue),
      .rd1   (rd1),
      .rd2   (rd2)
   );

   executeStage u_execute (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .pc       (pc),
      .rd1      (rd1),
      .rd2      (rd2),
      .wbValue  (wbValue),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .imm      (imm),
      .opcode   (opcode),
      .funct3   (funct3),
      .aluOp    (aluOp),
      .useImmB  (useImmB),
      .useZeroA (useZeroA),
      .usePcA   (usePcA),
      .regWe    (regWe),
      .wbSel    (wbSel),
      .isBranch (isBranch),
      .isJal    (isJal),
      .isJalr   (isJalr),
      .isLoad   (isLoad),
      .isStore  (isStore),
      .redirect (redirect),
      .target   (target),
      .memWe    (memWe),
      .memRe    (memRe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .wRd      (wRd),
      .wRegWe   (wRegWe),
      .wWbSel   (wWbSel),
      .wAluOut  (wAluOut),
      .wLink    (wLink),
      .wIsLoad  ()
   );

   writebackStage u_writeback (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .memWe    (memWe),
      .memRe    (memRe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .wWbSel   (wWbSel),
      .wAluOut  (wAluOut),
      .wLink    (wLink),
      .wbValue  (wbValue),
      .ioValid  (ioValid),
      .ioData   (ioData)
   );

endmodule

// ==== hdl/writebackStage.sv ====
// Data memory, output port and write-back select
`timescale 1ns/100ps
`include "riscv_defs.svh"

module writebackStage import riscvPkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall,
   input  logic               memWe,
   input  logic               memRe,
   input  logic [`XLEN-1:0]   memAddr,
   input  logic [`XLEN-1:0]   memWdata,
   input  wbSelT              wWbSel,
   input  logic [`XLEN-1:0]   wAluOut,
   input  logic [`XLEN-1:0]   wLink,
   output logic [`XLEN-1:0]   wbValue,
   output logic               ioValid,
   output logic [`XLEN-1:0]   ioData
);

   logic [`XLEN-1:0] dmem [0:`DMEM_WORDS-1];
   logic [`XLEN-1:0] memRdata;
   logic             isIo;
   logic             ioPending;

   // Bit 31 selects the output register
   assign isIo = |(memAddr & `IO_ADDR);

   // Word access only, low two address bits ignored
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         if (memWe && !isIo)
            dmem[memAddr[9:2]] <= memWdata;
         if (memRe)
            memRdata <= dmem[memAddr[9:2]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         ioPending <= 1'b0;
      else if (!stall)
         ioPending <= memWe && isIo;
   end

   always_ff @(posedge clk)
   begin
      if (!stall && memWe && isIo)
         ioData <= memWdata;
   end

   // Held store shows once the stall drops
   assign ioValid = ioPending && !stall;

   always_comb
   begin
      case (wWbSel)
         wbMem:   wbValue = memRdata;
         wbLink:  wbValue = wLink;
         default: wbValue = wAluOut;
      endcase
   end

endmodule

// ==== hdl/executeStage.sv ====
// Execute stage and X/W pipeline register
`timescale 1ns/100ps
`include "riscv_defs.svh"

module executeStage import riscvPkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall,
   input  logic [`XLEN-1:0]   pc,
   input  logic [`XLEN-1:0]   rd1,
   input  logic [`XLEN-1:0]   rd2,
   input  logic [`XLEN-1:0]   wbValue,
   input  logic [4:0]         rs1,
   input  logic [4:0]         rs2,
   input  logic [4:0]         rd,
   input  logic [`XLEN-1:0]   imm,
   input  opcodeT             opcode,
   input  logic [2:0]         funct3,
   input  aluOpT              aluOp,
   input  logic               useImmB,
   input  logic               useZeroA,
   input  logic               usePcA,
   input  logic               regWe,
   input  wbSelT              wbSel,
   input  logic               isBranch,
   input  logic               isJal,
   input  logic               isJalr,
   input  logic               isLoad,
   input  logic               isStore,
   output logic               redirect,
   output logic [`XLEN-1:0]   target,
   output logic               memWe,
   output logic               memRe,
   output logic [`XLEN-1:0]   memAddr,
   output logic [`XLEN-1:0]   memWdata,
   output logic [4:0]         wRd,
   output logic               wRegWe,
   output wbSelT              wWbSel,
   output logic [`XLEN-1:0]   wAluOut,
   output logic [`XLEN-1:0]   wLink,
   output logic               wIsLoad
);

   logic             usesRs1, usesRs2;
   logic             fwdA, fwdB;
   logic [`XLEN-1:0] src1, src2, aluA, aluB, aluResult;
   logic             takeBranch;

   // Only real source operands take the W forward
   assign usesRs1 = !(opcode == opLui || opcode == opAuipc || opcode == opJal);
   assign usesRs2 = (opcode == opReg) || isBranch || isStore;
   assign fwdA    = wRegWe && (wRd == rs1) && usesRs1;
   assign fwdB    = wRegWe && (wRd == rs2) && usesRs2;
   assign src1    = fwdA ? wbValue : rd1;
   assign src2    = fwdB ? wbValue : rd2;

   assign aluA = usePcA ? pc : (useZeroA ? '0 : src1);
   assign aluB = useImmB ? imm : src2;

   aluUnit u_alu (
      .a      (aluA),
      .b      (aluB),
      .op     (aluOp),
      .result (aluResult)
   );

   always_comb
   begin
      case (funct3)
         3'b000:  takeBranch = (src1 == src2);
         3'b001:  takeBranch = (src1 != src2);
         3'b100:  takeBranch = ($signed(src1) < $signed(src2));
         3'b101:  takeBranch = ($signed(src1) >= $signed(src2));
         3'b110:  takeBranch = (src1 < src2);
         3'b111:  takeBranch = (src1 >= src2);
         default: takeBranch = 1'b0;
      endcase
   end

   assign redirect = (isBranch && takeBranch) || isJal || isJalr;
   assign target   = isJalr ? {aluResult[`XLEN-1:1], 1'b0} : pc + imm;

   // Memory strobes leave X and act at the X/W edge
   assign memWe    = isStore;
   assign memRe    = isLoad;
   assign memAddr  = aluResult;
   assign memWdata = src2;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wRd     <= 5'd0;
         wRegWe  <= 1'b0;
         wWbSel  <= wbAlu;
         wIsLoad <= 1'b0;
      end
      else if (!stall)
      begin
         wRd     <= rd;
         wRegWe  <= regWe;
         wWbSel  <= wbSel;
         wIsLoad <= isLoad;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         wAluOut <= aluResult;
         wLink   <= pc + 32'd4;
      end
   end

endmodule

// ==== hdl/aluUnit.sv ====
// Integer ALU
`timescale 1ns/100ps
`include "riscv_defs.svh"

module aluUnit import riscvPkg::*; (
   input  logic [`XLEN-1:0]   a,
   input  logic [`XLEN-1:0]   b,
   input  aluOpT              op,
   output logic [`XLEN-1:0]   result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb
   begin
      case (op)
         aluAdd:   result = a + b;
         aluSub:   result = a - b;
         aluSll:   result = a << shamt;
         aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
         aluSltu:  result = {31'b0, a < b};
         aluXor:   result = a ^ b;
         aluSrl:   result = a >> shamt;
         aluSra:   result = $signed(a) >>> shamt;
         aluOr:    result = a | b;
         aluAnd:   result = a & b;
         aluPassB: result = b;
         default:  result = '0;
      endcase
   end

endmodule

// ==== hdl/regFile.sv ====
// Integer register file
`timescale 1ns/100ps
`include "riscv_defs.svh"

module regFile (
   input  logic               clk,
   input  logic               stall,
   input  logic               we,
   input  logic [4:0]         ra1,
   input  logic [4:0]         ra2,
   input  logic [4:0]         wa,
   input  logic [`XLEN-1:0]   wd,
   output logic [`XLEN-1:0]   rd1,
   output logic [`XLEN-1:0]   rd2
);

   logic [`XLEN-1:0] regs [0:31];

   // x0 is never written
   always_ff @(posedge clk)
   begin
      if (we && !stall && (wa != 5'd0))
         regs[wa] <= wd;
   end

   // Same-cycle writes reach X through the W forward instead
   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== hdl/decodeControl.sv ====
// Instruction decode and control
`timescale 1ns/100ps
`include "riscv_defs.svh"

module decodeControl import riscvPkg::*; (
   input  logic [`XLEN-1:0]   instr,
   output logic [4:0]         rs1,
   output logic [4:0]         rs2,
   output logic [4:0]         rd,
   output logic [`XLEN-1:0]   imm,
   output opcodeT             opcode,
   output logic [2:0]         funct3,
   output aluOpT              aluOp,
   output logic               useImmB,
   output logic               useZeroA,
   output logic               usePcA,
   output logic               regWe,
   output wbSelT              wbSel,
   output logic               isBranch,
   output logic               isJal,
   output logic               isJalr,
   output logic               isLoad,
   output logic               isStore
);

   logic [`XLEN-1:0] immI, immS, immBr, immU, immJ;
   logic             altOp;
   logic             writesRd;

   assign opcode = opcodeT'(instr[6:0]);
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   // funct7 bit 5 picks SUB and SRA
   assign altOp  = instr[30];

   assign immI  = {{20{instr[31]}}, instr[31:20]};
   assign immS  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immBr = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU  = {instr[31:12], 12'b0};
   assign immJ  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb
   begin
      imm      = immI;
      aluOp    = aluAdd;
      useImmB  = 1'b0;
      useZeroA = 1'b0;
      usePcA   = 1'b0;
      writesRd = 1'b0;
      wbSel    = wbAlu;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      case (opcode)
         opLui:
         begin
            imm      = immU;
            useImmB  = 1'b1;
            useZeroA = 1'b1;
            writesRd = 1'b1;
         end
         opAuipc:
         begin
            imm      = immU;
            useImmB  = 1'b1;
            usePcA   = 1'b1;
            writesRd = 1'b1;
         end
         opJal:
         begin
            imm      = immJ;
            isJal    = 1'b1;
            writesRd = 1'b1;
            wbSel    = wbLink;
         end
         opJalr:
         begin
            // ALU forms rs1 + imm for the target
            useImmB  = 1'b1;
            isJalr   = 1'b1;
            writesRd = 1'b1;
            wbSel    = wbLink;
         end
         opBranch:
         begin
            imm      = immBr;
            aluOp    = aluSub;
            isBranch = 1'b1;
         end
         opLoad:
         begin
            useImmB  = 1'b1;
            isLoad   = 1'b1;
            writesRd = 1'b1;
            wbSel    = wbMem;
         end
         opStore:
         begin
            imm     = immS;
            useImmB = 1'b1;
            isStore = 1'b1;
         end
         opImm, opReg:
         begin
            useImmB  = (opcode == opImm);
            writesRd = 1'b1;
            case (funct3)
               3'b000:  aluOp = (opcode == opReg && altOp) ? aluSub : aluAdd;
               3'b001:  aluOp = aluSll;
               3'b010:  aluOp = aluSlt;
               3'b011:  aluOp = aluSltu;
               3'b100:  aluOp = aluXor;
               3'b101:  aluOp = altOp ? aluSra : aluSrl;
               3'b110:  aluOp = aluOr;
               default: aluOp = aluAnd;
            endcase
         end
         // Anything else runs as a no-op
         default: writesRd = 1'b0;
      endcase
      regWe = writesRd && (rd != 5'd0);
   end

endmodule

// ==== hdl/fetchStage.sv ====
// Instruction fetch stage
`timescale 1ns/100ps
`include "riscv_defs.svh"

module fetchStage (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall,
   input  logic               loadEn,
   input  logic [7:0]         loadAddr,
   input  logic [`XLEN-1:0]   loadData,
   input  logic               redirect,
   input  logic [`XLEN-1:0]   target,
   output logic [`XLEN-1:0]   instr,
   output logic [`XLEN-1:0]   pc
);

   logic [`XLEN-1:0] imem [0:`IMEM_WORDS-1];
   logic [`XLEN-1:0] fetchPc;

   // Program loader, only while the core is held in reset
   always_ff @(posedge clk)
   begin
      if (rst && loadEn)
         imem[loadAddr] <= loadData;
   end

   // Synchronous read; pc tracks the word now in instr
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fetchPc <= '0;
         pc      <= '0;
         instr   <= `NOP_INSTR;
      end
      else if (!stall)
      begin
         pc <= fetchPc;
         if (redirect)
         begin
            // Squash the slot fetched behind the jump
            fetchPc <= target;
            instr   <= `NOP_INSTR;
         end
         else
         begin
            fetchPc <= fetchPc + 32'd4;
            instr   <= imem[fetchPc[9:2]];
         end
      end
   end

endmodule

// ==== hdl/riscvPkg.sv ====
// RV32I core types
package riscvPkg;

   // Major opcodes, instr[6:0]
   typedef enum logic [6:0] {
      opLui    = 7'b0110111,
      opAuipc  = 7'b0010111,
      opJal    = 7'b1101111,
      opJalr   = 7'b1100111,
      opBranch = 7'b1100011,
      opLoad   = 7'b0000011,
      opStore  = 7'b0100011,
      opImm    = 7'b0010011,
      opReg    = 7'b0110011
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluSll   = 4'd2,
      aluSlt   = 4'd3,
      aluSltu  = 4'd4,
      aluXor   = 4'd5,
      aluSrl   = 4'd6,
      aluSra   = 4'd7,
      aluOr    = 4'd8,
      aluAnd   = 4'd9,
      aluPassB = 4'd10
   } aluOpT;

   // Write-back source
   typedef enum logic [1:0] {wbAlu = 2'd0, wbMem = 2'd1, wbLink = 2'd2} wbSelT;

endpackage

// ==== hdl/riscv_defs.svh ====
// RV32I core constants
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// Register and datapath width
`define XLEN 32

// On-chip memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// Output register, decoded on address bit 31 alone
`define IO_ADDR 32'h8000_0000

// ADDI x0,x0,0
`define NOP_INSTR 32'h0000_0013

`endif
